/* source/ddr_pkg.sv */
package ddr_pkg;

    // word and line geometry
    localparam int word_bits      = 64;
    localparam int words_per_line = 8;
    localparam int line_bits      = word_bits * words_per_line;  // one burst line

    typedef logic [63:0]          addr_t;  // byte address
    typedef logic [word_bits-1:0] word_t;
    typedef logic [line_bits-1:0] line_t;

    // physical address that lands on word 0 of the array
    localparam addr_t ddr_base = 64'h0000_0000_8000_0000;

    // start-up contents are this value plus the word index
    localparam word_t init_pattern = 64'hA0A0_B0B0_C0C0_D0D0;

    // access latencies in clock cycles
    localparam int burst_latency_default  = 80;  // 512-bit line
    localparam int single_latency_default = 64;  // one 64-bit word

endpackage

/* source/ddr_bus_if.sv */
`timescale 1ns/1ns

// one memory operation between the arbiter and the ddr model
interface ddr_bus_if;

    logic           chip_enable;     // one-cycle start pulse
    ddr_pkg::addr_t index;           // byte address
    logic           write_enable;    // 1 write, 0 read
    logic           burst_mode;      // 1 full line, 0 single word in lane 0
    ddr_pkg::line_t write_mask;      // per-bit write enable
    ddr_pkg::line_t write_data;

    ddr_pkg::line_t read_data;       // held until the next read finishes
    logic           ready;           // high while idle
    logic           operation_done;  // pulse on ready rising

    modport master (
        output chip_enable, index, write_enable, burst_mode, write_mask, write_data,
        input  read_data, ready, operation_done
    );

    modport slave (
        input  chip_enable, index, write_enable, burst_mode, write_mask, write_data,
        output read_data, ready, operation_done
    );

endinterface

/* source/simddr.sv */
`timescale 1ns/1ns

module simddr #(
    parameter int depth_words    = 4096,
    parameter int burst_latency  = ddr_pkg::burst_latency_default,
    parameter int single_latency = ddr_pkg::single_latency_default
) (
    input logic      clock,
    input logic      reset_n,
    ddr_bus_if.slave bus
);

    localparam int idx_bits = $clog2(depth_words);  // index wraps within the array
    // last counter value of each mode
    localparam logic [7:0] burst_last  = 8'(burst_latency - 1);
    localparam logic [7:0] single_last = 8'(single_latency - 1);

    ddr_pkg::word_t mem [depth_words];  // backing store, one word per entry

    // request latches
    logic                write_enable_q;
    logic                burst_mode_q;
    ddr_pkg::line_t      write_data_q;
    ddr_pkg::line_t      write_mask_q;
    logic [idx_bits-1:0] word_index_q;

    logic                ready_q;
    logic                ready_dly;      // ready one cycle late, for edge detect
    logic                busy;           // operation in flight
    logic [7:0]          cycle_counter;
    logic [7:0]          last_value;
    logic                access;         // final cycle, array is touched here

    ddr_pkg::addr_t      offset_address;
    logic [idx_bits-1:0] word_index;
    logic [idx_bits-1:0] lane_index [ddr_pkg::words_per_line];

    // byte offset from the ddr window, then down to 64-bit words
    assign offset_address = bus.index - ddr_pkg::ddr_base;
    assign word_index     = bus.burst_mode ? {offset_address[idx_bits+2:6], 3'b000}
                                           : offset_address[idx_bits+2:3];

    // word addresses of the eight lanes of a line
    always_comb begin
        for (int k = 0; k < ddr_pkg::words_per_line; k++) begin
            lane_index[k] = word_index_q | idx_bits'(k);
        end
    end

    function automatic ddr_pkg::word_t merge_word(input ddr_pkg::word_t old_word,
                                                  input ddr_pkg::word_t new_word,
                                                  input ddr_pkg::word_t mask);
        return (old_word & ~mask) | (new_word & mask);  // mask bit 1 takes new data
    endfunction

    // known start-up contents
    initial begin
        for (int i = 0; i < depth_words; i++) begin
            mem[i] = ddr_pkg::init_pattern + ddr_pkg::word_t'(i);
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            write_enable_q <= 1'b0;
            burst_mode_q   <= 1'b0;
        end else if (bus.chip_enable) begin
            write_enable_q <= bus.write_enable;
            burst_mode_q   <= bus.burst_mode;
        end
    end

    always_ff @(posedge clock) begin
        if (bus.chip_enable) begin
            write_data_q <= bus.write_data;
            write_mask_q <= bus.write_mask;
            word_index_q <= word_index;
        end
    end

    assign last_value = burst_mode_q ? burst_last : single_last;
    assign access     = busy && !bus.chip_enable && (cycle_counter == last_value);

    // latency counter, a new chip_enable restarts it
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            cycle_counter <= 8'd0;
            busy          <= 1'b0;
            ready_q       <= 1'b1;
        end else if (bus.chip_enable) begin
            cycle_counter <= 8'd0;
            busy          <= 1'b1;
            ready_q       <= 1'b0;
        end else if (access) begin
            cycle_counter <= 8'd0;
            busy          <= 1'b0;
            ready_q       <= 1'b1;  // done pulse follows next cycle
        end else if (busy) begin
            cycle_counter <= cycle_counter + 8'd1;
        end
    end

    // array access on the last count
    always @(posedge clock) begin
        if (access) begin
            if (burst_mode_q) begin
                for (int k = 0; k < ddr_pkg::words_per_line; k++) begin
                    if (write_enable_q) begin
                        mem[lane_index[k]] <= merge_word(mem[lane_index[k]],
                            write_data_q[k*ddr_pkg::word_bits +: ddr_pkg::word_bits],
                            write_mask_q[k*ddr_pkg::word_bits +: ddr_pkg::word_bits]);
                    end else begin
                        bus.read_data[k*ddr_pkg::word_bits +: ddr_pkg::word_bits] <=
                            mem[lane_index[k]];
                    end
                end
            end else if (write_enable_q) begin
                mem[word_index_q] <= merge_word(mem[word_index_q],
                                                write_data_q[ddr_pkg::word_bits-1:0],
                                                write_mask_q[ddr_pkg::word_bits-1:0]);
            end else begin
                bus.read_data <= ddr_pkg::line_t'(mem[word_index_q]);  // lane 0, rest zero
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ready_dly <= 1'b1;
        end else begin
            ready_dly <= ready_q;
        end
    end

    assign bus.ready          = ready_q;
    assign bus.operation_done = ready_q & ~ready_dly;  // rising edge of ready

    // requester must wait for the previous operation to finish
    a_no_enable_while_busy: assert property (
        @(posedge clock) disable iff (!reset_n) bus.chip_enable |-> ready_q
    ) else $error("simddr: chip_enable while an operation is in progress");

    a_done_single_pulse: assert property (
        @(posedge clock) disable iff (!reset_n) bus.operation_done |=> !bus.operation_done
    ) else $error("simddr: operation_done held for two cycles");

endmodule

/* source/ddr_arbiter.sv */
`timescale 1ns/1ns

module ddr_arbiter (
    input  logic             clock,
    input  logic             reset_n,
    input  logic             fetch_req,
    input  ddr_pkg::addr_t   fetch_addr,
    input  logic             data_req,
    input  ddr_pkg::addr_t   data_addr,
    input  logic             data_write,
    input  ddr_pkg::word_t   data_wdata,
    input  ddr_pkg::word_t   data_wmask,
    output ddr_pkg::line_t   fetch_line,
    output logic             fetch_done,
    output ddr_pkg::word_t   data_rdata,
    output logic             data_done,
    ddr_bus_if.master        bus
);

    typedef enum logic [1:0] {
        st_idle,
        st_issue,   // chip_enable cycle
        st_wait     // until operation_done
    } state_t;

    state_t         state;
    logic           owner_data;    // set while the data port holds the grant
    logic           hold;          // one idle cycle after a completion
    logic           fetch_ok;
    logic           data_ok;
    logic           data_read_done;
    ddr_pkg::line_t fetch_line_q;
    ddr_pkg::word_t data_rdata_q;

    // nothing is granted until the memory reports ready
    // the port that just finished is not granted again straight away
    assign data_ok  = bus.ready && data_req && !(hold && owner_data);
    assign fetch_ok = bus.ready && fetch_req && !(hold && !owner_data);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state      <= st_idle;
            owner_data <= 1'b0;
            hold       <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    hold <= 1'b0;
                    if (data_ok) begin            // data port wins a tie
                        owner_data <= 1'b1;
                        state      <= st_issue;
                    end else if (fetch_ok) begin
                        owner_data <= 1'b0;
                        state      <= st_issue;
                    end
                end
                st_issue: state <= st_wait;
                st_wait: begin
                    if (bus.operation_done) begin
                        state <= st_idle;
                        hold  <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // request fields follow the owner while requesters hold them stable
    assign bus.chip_enable  = (state == st_issue);
    assign bus.burst_mode   = !owner_data;
    assign bus.write_enable = owner_data && data_write;  // fetch only reads
    assign bus.index        = owner_data ? data_addr : {fetch_addr[63:6], 6'b000000};
    assign bus.write_mask   = owner_data ? ddr_pkg::line_t'(data_wmask) : '0;
    assign bus.write_data   = owner_data ? ddr_pkg::line_t'(data_wdata) : '0;

    assign fetch_done     = (state == st_wait) && !owner_data && bus.operation_done;
    assign data_done      = (state == st_wait) && owner_data && bus.operation_done;
    assign data_read_done = data_done && !data_write;  // writes leave rdata alone

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            fetch_line_q <= '0;
            data_rdata_q <= '0;
        end else begin
            if (fetch_done) fetch_line_q <= bus.read_data;
            if (data_read_done) data_rdata_q <= bus.read_data[ddr_pkg::word_bits-1:0];
        end
    end

    // bypass so the result is already there in the done cycle
    assign fetch_line = fetch_done ? bus.read_data : fetch_line_q;
    assign data_rdata = data_read_done ? bus.read_data[ddr_pkg::word_bits-1:0] : data_rdata_q;

    a_done_exclusive: assert property (
        @(posedge clock) disable iff (!reset_n) !(fetch_done && data_done)
    ) else $error("ddr_arbiter: fetch_done and data_done together");

    // done only ever answers a request that is still held
    a_fetch_done_has_req: assert property (
        @(posedge clock) disable iff (!reset_n) fetch_done |-> fetch_req
    ) else $error("ddr_arbiter: fetch_done without a pending fetch_req");

    a_data_done_has_req: assert property (
        @(posedge clock) disable iff (!reset_n) data_done |-> data_req
    ) else $error("ddr_arbiter: data_done without a pending data_req");

endmodule

/* source/simddr_sys.sv */
`timescale 1ns/1ns

// memory subsystem top, fetch and data ports share one ddr model
module simddr_sys #(
    parameter int depth_words    = 4096,
    parameter int burst_latency  = ddr_pkg::burst_latency_default,
    parameter int single_latency = ddr_pkg::single_latency_default
) (
    input  logic           clock,
    input  logic           reset_n,
    // instruction fetch, whole lines
    input  logic           fetch_req,
    input  ddr_pkg::addr_t fetch_addr,
    output ddr_pkg::line_t fetch_line,
    output logic           fetch_done,
    // data port, single masked words
    input  logic           data_req,
    input  ddr_pkg::addr_t data_addr,
    input  logic           data_write,
    input  ddr_pkg::word_t data_wdata,
    input  ddr_pkg::word_t data_wmask,
    output ddr_pkg::word_t data_rdata,
    output logic           data_done
);

    ddr_bus_if ddr_bus ();  // arbiter to memory

    ddr_arbiter arbiter_inst (
        .clock      (clock),
        .reset_n    (reset_n),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .data_req   (data_req),
        .data_addr  (data_addr),
        .data_write (data_write),
        .data_wdata (data_wdata),
        .data_wmask (data_wmask),
        .fetch_line (fetch_line),
        .fetch_done (fetch_done),
        .data_rdata (data_rdata),
        .data_done  (data_done),
        .bus        (ddr_bus.master)
    );

    simddr #(
        .depth_words    (depth_words),
        .burst_latency  (burst_latency),
        .single_latency (single_latency)
    ) simddr_inst (
        .clock   (clock),
        .reset_n (reset_n),
        .bus     (ddr_bus.slave)
    );

endmodule

/* test/simddr_sys_tb.sv */
`timescale 1ns/1ns

module simddr_sys_tb;

    localparam int depth_words    = 4096;
    localparam int burst_latency  = ddr_pkg::burst_latency_default;
    localparam int single_latency = ddr_pkg::single_latency_default;
    localparam int wait_limit     = 400;  // cycles per done wait

    logic clock = 1'b0;
    logic reset_n, fetch_req, data_req, data_write, fetch_done, data_done;
    ddr_pkg::addr_t fetch_addr, data_addr;
    ddr_pkg::word_t data_wdata, data_wmask, data_rdata;
    ddr_pkg::line_t fetch_line;

    ddr_pkg::word_t shadow [depth_words];   // expected memory contents
    logic [31:0]    lfsr_state = 32'h96dd_1d87;
    int             error_count, timeout_count;

    simddr_sys #(
        .depth_words    (depth_words),
        .burst_latency  (burst_latency),
        .single_latency (single_latency)
    ) simddr_sys_inst (.*);

    always #10 clock = ~clock;  // 20 ns period

    // galois lfsr, one step per bit taken
    function automatic logic [63:0] random_bits(input int count);
        logic [63:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'hB400_0000 : 32'h0);
            value      = {value[62:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic ddr_pkg::addr_t word_addr(input int idx);
        return ddr_pkg::ddr_base + (ddr_pkg::addr_t'(idx) << 3);  // 8 bytes per word
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    // one single-word access on the data port, cycles counts from the edge that sees req
    task automatic data_access(input logic write, input ddr_pkg::addr_t addr,
                               input ddr_pkg::word_t wdata, input ddr_pkg::word_t wmask,
                               output ddr_pkg::word_t rdata, output int cycles);
        int   waited;
        logic seen;
        @(posedge clock);
        data_req   <= 1'b1;
        data_addr  <= addr;
        data_write <= write;
        data_wdata <= wdata;
        data_wmask <= wmask;
        waited = 0;
        seen   = 1'b0;
        rdata  = '0;
        while (!seen && waited < wait_limit) begin
            @(negedge clock);  // outputs settled mid-cycle
            waited++;
            if (data_done) begin
                seen  = 1'b1;
                rdata = data_rdata;
            end
        end
        if (!seen) begin
            timeout_count++;
            $display("data port got no done within %0d cycles, address %h", wait_limit, addr);
        end
        cycles = waited - 2;
        @(posedge clock);
        data_req <= 1'b0;  // drop in the cycle after done
    endtask

    task automatic do_write(input int idx, input ddr_pkg::word_t wdata,
                            input ddr_pkg::word_t wmask);
        ddr_pkg::word_t unused_rdata;
        int             unused_cycles;
        data_access(1'b1, word_addr(idx), wdata, wmask, unused_rdata, unused_cycles);
        shadow[idx] = (shadow[idx] & ~wmask) | (wdata & wmask);  // mask 1 takes new bits
    endtask

    task automatic do_read(input int idx, output int cycles);
        ddr_pkg::word_t rdata;
        data_access(1'b0, word_addr(idx), '0, '0, rdata, cycles);
        check($sformatf("data_rdata word %0d", idx), shadow[idx], rdata);
    endtask

    task automatic do_fetch(input ddr_pkg::addr_t addr, output int cycles);
        int             waited;
        int             base;
        logic           seen;
        ddr_pkg::line_t line;
        @(posedge clock);
        fetch_req  <= 1'b1;
        fetch_addr <= addr;
        waited = 0;
        seen   = 1'b0;
        line   = '0;
        base   = int'((addr - ddr_pkg::ddr_base) >> 6) * 8;  // first word of the line
        while (!seen && waited < wait_limit) begin
            @(negedge clock);
            waited++;
            if (fetch_done) begin
                seen = 1'b1;
                line = fetch_line;
            end
        end
        if (!seen) begin
            timeout_count++;
            $display("fetch port got no done within %0d cycles, address %h", wait_limit, addr);
        end
        cycles = waited - 2;
        @(posedge clock);
        fetch_req <= 1'b0;
        for (int k = 0; k < ddr_pkg::words_per_line; k++) begin
            check($sformatf("fetch_line word %0d", k), shadow[base + k], line[k*64 +: 64]);
        end
    endtask

    // the two ports never finish in the same cycle
    always @(negedge clock) begin
        if (reset_n && fetch_done && data_done) begin
            error_count++;
            $display("fetch_done and data_done were high together at %0t", $time);
        end
    end

    initial begin
        int lat_d, lat_f, idx;
        reset_n       = 1'b0;
        fetch_req     = 1'b0;
        fetch_addr    = '0;
        data_req      = 1'b0;
        data_addr     = '0;
        data_write    = 1'b0;
        data_wdata    = '0;
        data_wmask    = '0;
        error_count   = 0;
        timeout_count = 0;
        for (int i = 0; i < depth_words; i++) begin
            shadow[i] = ddr_pkg::init_pattern + ddr_pkg::word_t'(i);
        end
        repeat (3) @(posedge clock);
        reset_n <= 1'b1;

        // idle outputs, then an untouched word
        @(negedge clock);
        check("fetch_done", 64'd0, 64'(fetch_done));
        check("data_done", 64'd0, 64'(data_done));
        check("data_rdata", 64'd0, data_rdata);
        for (int k = 0; k < ddr_pkg::words_per_line; k++) begin
            check($sformatf("fetch_line word %0d", k), 64'd0, fetch_line[k*64 +: 64]);
        end
        do_read(5, lat_d);

        do_write(10, 64'h1234_5678_9ABC_DEF0, 64'hFFFF_0000_00FF_FF00);  // partial mask
        do_read(10, lat_d);

        // fill one line word by word, fetch it from inside the line
        for (int k = 0; k < ddr_pkg::words_per_line; k++) begin
            do_write(64 + k, random_bits(64), '1);
        end
        do_fetch(word_addr(64) + 64'h1C, lat_f);

        // both ports in the same cycle, data wins
        fork
            do_read(67, lat_d);
            do_fetch(word_addr(128) + 64'h8, lat_f);
        join
        check("data_done before fetch_done", 64'd1, 64'(lat_d < lat_f));

        // idle-arbiter latencies
        do_read(20, lat_d);
        check("data latency", 64'(single_latency + 1), 64'(lat_d));
        do_fetch(word_addr(256), lat_f);
        check("fetch latency", 64'(burst_latency + 1), 64'(lat_f));

        repeat (40) begin
            idx = int'(random_bits(32) % 64'(depth_words));
            do_write(idx, random_bits(64), random_bits(64));
            do_read(idx, lat_d);
        end

        $display("errors %0d timeouts %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* simddr_sys.f */
source/ddr_pkg.sv
source/ddr_bus_if.sv
source/simddr.sv
source/ddr_arbiter.sv
source/simddr_sys.sv
test/simddr_sys_tb.sv

/* Makefile */
TOP = simddr_sys_tb

all: run

obj_dir/V$(TOP): simddr_sys.f source/*.sv test/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f simddr_sys.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -qx "sim passed" sim.log

lint:
	verilator --lint-only --timing --top-module $(TOP) -f simddr_sys.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
